//--- build.f
source/ps_pkg.sv
source/ps_stream_if.sv
source/ps_traffic_generator.sv
source/ps_register_slice.sv
source/ps_stream_monitor.sv
source/ps_traffic_top.sv
tests/ps_traffic_tb.sv

//--- Bender.yml
package:
  name: ps_traffic

sources:
  # Design, in compile order
  - source/ps_pkg.sv
  - source/ps_stream_if.sv
  - source/ps_traffic_generator.sv
  - source/ps_register_slice.sv
  - source/ps_stream_monitor.sv
  - source/ps_traffic_top.sv

  # Testbench
  - target: test
    files:
      - tests/ps_traffic_tb.sv

//--- tests/ps_traffic_tb.sv
module ps_traffic_tb import ps_pkg::*; ();

    // ------------------------------
    // Run lengths and watchdog

    localparam int unsigned RUN_STEADY      = 20;  // Multiple of its length
    localparam int unsigned RUN_RANDOM      = 23;  // Not a multiple of its length
    localparam int unsigned RUN_SINGLE      = 10;
    localparam int unsigned RUN_ABORT       = 40;  // Cut short
    localparam int unsigned RUN_WRAP        = 17;
    localparam int unsigned TOTAL_WORDS     = RUN_STEADY + RUN_RANDOM + RUN_SINGLE
                                            + RUN_ABORT + RUN_WRAP;
    localparam int unsigned WATCHDOG_CYCLES = TOTAL_WORDS * 8 + 200;

    logic                    reset;  // Clock
    logic                    clk;    // Reset, active high
    ps_reg_addr_e            i_ctrl_addr;
    logic                    i_ctrl_wreq;
    logic [PS_WIDTH-1:0]     i_ctrl_wdat;
    logic [PS_WIDTH-1:0]     o_ctrl_rdat;
    logic                    i_rdy;
    logic [PS_WIDTH-1:0]     o_dat;
    logic                    o_val;
    logic                    o_eop;
    logic [PS_CNT_WIDTH-1:0] o_word_cnt;
    logic [PS_CNT_WIDTH-1:0] o_pkt_cnt;
    logic [PS_CNT_WIDTH-1:0] o_last_len;
    logic [PS_WIDTH-1:0]     o_checksum;

    // Reference list, head is the next word due
    logic [PS_WIDTH-1:0]     exp_dat[$];
    logic                    exp_eop[$];
    logic [PS_CNT_WIDTH-1:0] exp_word_cnt;
    logic [PS_CNT_WIDTH-1:0] exp_pkt_cnt;
    logic [PS_CNT_WIDTH-1:0] exp_last_len;
    logic [PS_CNT_WIDTH-1:0] exp_run_len;   // Open packet, survives an abort
    logic [PS_WIDTH-1:0]     exp_checksum;
    int unsigned             n_xfer;        // Words taken at the output
    bit                      rdy_random;    // Back-pressure on
    string                   test_name;
    int unsigned             seed;

    ps_traffic_top DUT (
        .reset       (reset),
        .clk         (clk),
        .i_ctrl_addr (i_ctrl_addr),
        .i_ctrl_wreq (i_ctrl_wreq),
        .i_ctrl_wdat (i_ctrl_wdat),
        .o_ctrl_rdat (o_ctrl_rdat),
        .i_rdy       (i_rdy),
        .o_dat       (o_dat),
        .o_val       (o_val),
        .o_eop       (o_eop),
        .o_word_cnt  (o_word_cnt),
        .o_pkt_cnt   (o_pkt_cnt),
        .o_last_len  (o_last_len),
        .o_checksum  (o_checksum)
    );

    always #10 reset = ~reset;  // Period 20

    // External ready, random or held high
    initial begin : ready_driver
        seed = $urandom(77);
        forever begin
            @(posedge reset);
            if (rdy_random) begin
                i_rdy <= (($urandom % 3) != 0);  // About two thirds ready
            end else begin
                i_rdy <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Reporting

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
    endtask

    task automatic report_mismatch(input string what, input int unsigned expected,
                                   input int unsigned actual);
        report_failure($sformatf("Error: %s, %s expected %0d actual %0d",
                                 test_name, what, expected, actual));
    endtask

    // ------------------------------
    // Reference model

    // Words and eop flags of one run, from the register values
    function automatic void build_expected(input logic [PS_WIDTH-1:0] data,
                                           input logic [PS_WIDTH-1:0] incr,
                                           input logic [PS_WIDTH-1:0] length,
                                           input logic [PS_WIDTH-1:0] amount);
        logic [PS_WIDTH-1:0] word;
        word = data;
        for (int k = 0; k < amount; k++) begin
            exp_dat.push_back(word);
            exp_eop.push_back(((k + 1) % length == 0) || (k == amount - 1));
            word = word + incr;  // Wraps at 256
        end
    endfunction

    // Output transfers, sampled mid-cycle while stable
    always @(negedge reset) begin : compare_output
        logic [PS_WIDTH-1:0] e_dat;
        logic                e_eop;
        if (!clk && o_val && i_rdy) begin
            assert (exp_dat.size() != 0)
                else begin
                    report_failure($sformatf("%s: a word left the DUT with none expected",
                                             test_name));
                    $fatal(1);
                end
            e_dat = exp_dat.pop_front();
            e_eop = exp_eop.pop_front();
            assert (o_dat == e_dat)
                else begin
                    report_mismatch($sformatf("data of word %0d", n_xfer), e_dat, o_dat);
                    $fatal(1);
                end
            assert (o_eop == e_eop)
                else begin
                    report_mismatch($sformatf("eop of word %0d", n_xfer), e_eop, o_eop);
                    $fatal(1);
                end
            // Statistics as the monitor should see them
            n_xfer       = n_xfer + 1;
            exp_word_cnt = exp_word_cnt + 1'b1;
            exp_checksum = exp_checksum + e_dat;
            if (e_eop) begin
                exp_pkt_cnt  = exp_pkt_cnt + 1'b1;
                exp_last_len = exp_run_len + 1'b1;
                exp_run_len  = '0;
            end else begin
                exp_run_len = exp_run_len + 1'b1;
            end
        end
    end

    // ------------------------------
    // Stimulus tasks

    task automatic write_reg(input ps_reg_addr_e addr, input logic [PS_WIDTH-1:0] wdat);
        @(posedge reset);
        i_ctrl_addr <= addr;
        i_ctrl_wreq <= 1'b1;
        i_ctrl_wdat <= wdat;
        @(posedge reset);  // Write lands here
        i_ctrl_wreq <= 1'b0;
    endtask

    task automatic check_reg(input ps_reg_addr_e addr, input logic [PS_WIDTH-1:0] exp_val);
        @(posedge reset);
        i_ctrl_addr <= addr;
        @(negedge reset);  // Readback is combinational
        assert (o_ctrl_rdat == exp_val)
            else begin
                report_mismatch($sformatf("readback at address %0d", addr), exp_val,
                                o_ctrl_rdat);
                $fatal(1);
            end
    endtask

    task automatic check_stats();
        assert (o_word_cnt == exp_word_cnt)
            else begin
                report_mismatch("word count", exp_word_cnt, o_word_cnt);
                $fatal(1);
            end
        assert (o_pkt_cnt == exp_pkt_cnt)
            else begin
                report_mismatch("packet count", exp_pkt_cnt, o_pkt_cnt);
                $fatal(1);
            end
        assert (o_last_len == exp_last_len)
            else begin
                report_mismatch("last packet length", exp_last_len, o_last_len);
                $fatal(1);
            end
        assert (o_checksum == exp_checksum)
            else begin
                report_mismatch("checksum", exp_checksum, o_checksum);
                $fatal(1);
            end
    endtask

    task automatic set_backpressure(input bit on);
        @(negedge reset);  // Away from the drive edge
        rdy_random = on;
    endtask

    task automatic start_run(input string name, input logic [PS_WIDTH-1:0] data,
                             input logic [PS_WIDTH-1:0] incr,
                             input logic [PS_WIDTH-1:0] length,
                             input logic [PS_WIDTH-1:0] amount);
        test_name = name;
        build_expected(data, incr, length, amount);
        write_reg(PS_REG_DATA, data);
        write_reg(PS_REG_INCR, incr);
        write_reg(PS_REG_LENGTH, length);
        write_reg(PS_REG_AMOUNT, amount);  // Starts the run
    endtask

    // Wait for the list to empty, then the generator must be idle
    task automatic finish_run();
        while (exp_dat.size() != 0) begin
            @(negedge reset);
        end
        @(posedge reset);  // Last transfer
        @(negedge reset);
        assert (o_val == 1'b0)
            else begin
                report_failure($sformatf("%s: output still valid after the last word",
                                         test_name));
                $fatal(1);
            end
        check_stats();
        check_reg(PS_REG_AMOUNT, '0);
    endtask

    // Stop a run midway, the slice may still hold two words
    task automatic abort_run(input logic [PS_WIDTH-1:0] data,
                             input logic [PS_WIDTH-1:0] incr,
                             input logic [PS_WIDTH-1:0] length);
        int unsigned base;
        int unsigned snap;
        base = n_xfer;
        start_run("abort mid run", data, incr, length, RUN_ABORT);
        while (n_xfer < base + 5) begin
            @(negedge reset);
        end
        write_reg(PS_REG_AMOUNT, '0);
        snap = n_xfer;
        @(negedge reset);
        while (o_val) begin
            @(negedge reset);
        end
        assert (n_xfer - snap <= 2)
            else begin
                report_failure($sformatf("%s: %0d words came out after the stop, two at most",
                                         test_name, n_xfer - snap));
                $fatal(1);
            end
        check_reg(PS_REG_AMOUNT, '0);
        exp_dat.delete();  // Words never generated
        exp_eop.delete();
        check_stats();
    endtask

    // ------------------------------
    // Test sequence

    initial begin : stimulus
        reset        = 1'b0;
        clk          = 1'b1;
        i_ctrl_addr  = PS_REG_DATA;
        i_ctrl_wreq  = 1'b0;
        i_ctrl_wdat  = '0;
        i_rdy        = 1'b1;
        rdy_random   = 1'b0;
        n_xfer       = 0;
        exp_word_cnt = '0;
        exp_pkt_cnt  = '0;
        exp_last_len = '0;
        exp_run_len  = '0;
        exp_checksum = '0;
        test_name    = "reset";
        repeat (5) @(posedge reset);
        clk <= 1'b0;

        @(negedge reset);
        assert (o_val == 1'b0)
            else begin
                report_failure("Output valid is high right after reset");
                $fatal(1);
            end
        check_stats();

        test_name = "register readback";
        write_reg(PS_REG_DATA, 8'h5A);
        check_reg(PS_REG_DATA, 8'h5A);
        write_reg(PS_REG_INCR, 8'h13);
        check_reg(PS_REG_INCR, 8'h13);
        write_reg(PS_REG_LENGTH, 8'h07);
        check_reg(PS_REG_LENGTH, 8'h07);
        check_reg(PS_REG_AMOUNT, '0);

        start_run("steady stream", 8'h10, 8'h03, 8'd4, RUN_STEADY);
        finish_run();

        set_backpressure(1'b1);
        start_run("random ready", 8'hF0, 8'h07, 8'd5, RUN_RANDOM);
        finish_run();
        start_run("one word packets", 8'h00, 8'h01, 8'd1, RUN_SINGLE);
        finish_run();

        abort_run(8'h40, 8'h02, 8'd3);
        start_run("wrap after abort", 8'hFE, 8'h55, 8'd6, RUN_WRAP);
        finish_run();

        if (exp_dat.size() != 0) begin
            report_failure("Expected words were left over at the end of the run");
            $fatal(1);
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

    // Ends a hung run
    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge reset);
        report_failure($sformatf("Timeout: the run hung in test %s after %0d cycles",
                                 test_name, WATCHDOG_CYCLES));
        $fatal(1);
    end

endmodule : ps_traffic_tb

//--- source/ps_traffic_top.sv
module ps_traffic_top import ps_pkg::*; (
    input  logic                    reset,  // Clock
    input  logic                    clk,    // Async reset, active high

    // Control port
    input  ps_reg_addr_e            i_ctrl_addr,
    input  logic                    i_ctrl_wreq,
    input  logic [PS_WIDTH-1:0]     i_ctrl_wdat,
    output logic [PS_WIDTH-1:0]     o_ctrl_rdat,

    // Outgoing stream
    input  logic                    i_rdy,
    output logic [PS_WIDTH-1:0]     o_dat,
    output logic                    o_val,
    output logic                    o_eop,

    // Monitor statistics
    output logic [PS_CNT_WIDTH-1:0] o_word_cnt,
    output logic [PS_CNT_WIDTH-1:0] o_pkt_cnt,
    output logic [PS_CNT_WIDTH-1:0] o_last_len,
    output logic [PS_WIDTH-1:0]     o_checksum
);

    // ------------------------------
    // Stream links

    ps_stream_if gen_to_slice ();
    ps_stream_if slice_to_mon ();

    // Source, register driven
    ps_traffic_generator u_generator (
        .reset       (reset),
        .clk         (clk),
        .i_ctrl_addr (i_ctrl_addr),
        .i_ctrl_wreq (i_ctrl_wreq),
        .i_ctrl_wdat (i_ctrl_wdat),
        .o_ctrl_rdat (o_ctrl_rdat),
        .o_stream    (gen_to_slice)
    );

    // One cycle of latency, cuts the ready path
    ps_register_slice u_slice (
        .reset    (reset),
        .clk      (clk),
        .i_stream (gen_to_slice),
        .o_stream (slice_to_mon)
    );

    ps_stream_monitor u_monitor (
        .reset      (reset),
        .clk        (clk),
        .i_stream   (slice_to_mon),
        .i_rdy      (i_rdy),
        .o_dat      (o_dat),
        .o_val      (o_val),
        .o_eop      (o_eop),
        .o_word_cnt (o_word_cnt),
        .o_pkt_cnt  (o_pkt_cnt),
        .o_last_len (o_last_len),
        .o_checksum (o_checksum)
    );

endmodule : ps_traffic_top

//--- source/ps_stream_monitor.sv
module ps_stream_monitor import ps_pkg::*; (
    input  logic                    reset,  // Clock
    input  logic                    clk,    // Async reset, active high

    ps_stream_if.snk                i_stream,
    input  logic                    i_rdy,  // External back-pressure

    // Forwarded stream
    output logic [PS_WIDTH-1:0]     o_dat,
    output logic                    o_val,
    output logic                    o_eop,

    // Statistics
    output logic [PS_CNT_WIDTH-1:0] o_word_cnt,
    output logic [PS_CNT_WIDTH-1:0] o_pkt_cnt,
    output logic [PS_CNT_WIDTH-1:0] o_last_len,
    output logic [PS_WIDTH-1:0]     o_checksum
);

    // ------------------------------
    // Pass-through

    logic                    xfer;     // Word accepted downstream
    logic [PS_CNT_WIDTH-1:0] run_len;  // Words so far in open packet

    assign o_dat        = i_stream.dat;
    assign o_val        = i_stream.val;
    assign o_eop        = i_stream.eop;
    assign i_stream.rdy = i_rdy;  // Ready goes straight back

    assign xfer = i_stream.val & i_rdy;

    // ------------------------------
    // Counters

    // Word count and checksum
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            o_word_cnt <= '0;
            o_checksum <= '0;
        end else if (xfer) begin
            o_word_cnt <= o_word_cnt + 1'b1;
            o_checksum <= o_checksum + i_stream.dat;  // Mod 2^PS_WIDTH
        end
    end

    // Packet boundaries
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            o_pkt_cnt  <= '0;
            o_last_len <= '0;
            run_len    <= '0;
        end else if (xfer) begin
            if (i_stream.eop) begin
                o_pkt_cnt  <= o_pkt_cnt + 1'b1;
                o_last_len <= run_len + 1'b1;  // Count the eop word too
                run_len    <= '0;
            end else begin
                run_len <= run_len + 1'b1;
            end
        end
    end

endmodule : ps_stream_monitor

//--- source/ps_register_slice.sv
module ps_register_slice import ps_pkg::*; (
    input  logic     reset,     // Clock
    input  logic     clk,       // Async reset, active high
    ps_stream_if.snk i_stream,  // From upstream
    ps_stream_if.src o_stream   // To downstream
);

    // ------------------------------
    // Storage

    logic [PS_WIDTH-1:0] main_dat;  // Head entry, drives the output
    logic                main_eop;
    logic                main_val;
    logic [PS_WIDTH-1:0] skid_dat;  // Catches a word while head stalls
    logic                skid_eop;
    logic                skid_val;
    logic                rdy_reg;   // Registered ready upstream

    logic in_xfer;
    logic out_xfer;
    logic load_main_in;    // Head takes the incoming word
    logic load_main_skid;  // Head takes the skid word
    logic load_skid;       // Skid takes the incoming word
    logic main_val_nxt;
    logic skid_val_nxt;

    assign in_xfer  = i_stream.val & rdy_reg;
    assign out_xfer = main_val & o_stream.rdy;

    // Routing, skid always drains ahead of new data
    always_comb begin
        load_main_skid = out_xfer & skid_val;
        load_main_in   = in_xfer & (~main_val | (out_xfer & ~skid_val));
        load_skid      = in_xfer & ~load_main_in;
        main_val_nxt   = load_main_in | load_main_skid | (main_val & ~out_xfer);
        skid_val_nxt   = load_skid | (skid_val & ~out_xfer);
    end

    // Occupancy and ready
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            main_val <= 1'b0;
            skid_val <= 1'b0;
            rdy_reg  <= 1'b0;  // High after the first edge
        end else begin
            main_val <= main_val_nxt;
            skid_val <= skid_val_nxt;
            rdy_reg  <= ~(main_val_nxt & skid_val_nxt);  // Room while under two
        end
    end

    // Payload, no reset
    always_ff @(posedge reset) begin
        if (load_main_in) begin
            main_dat <= i_stream.dat;
            main_eop <= i_stream.eop;
        end else if (load_main_skid) begin
            main_dat <= skid_dat;
            main_eop <= skid_eop;
        end
        if (load_skid) begin
            skid_dat <= i_stream.dat;
            skid_eop <= i_stream.eop;
        end
    end

    assign i_stream.rdy = rdy_reg;
    assign o_stream.dat = main_dat;
    assign o_stream.eop = main_eop;
    assign o_stream.val = main_val;

endmodule : ps_register_slice

//--- source/ps_traffic_generator.sv
module ps_traffic_generator import ps_pkg::*; (
    input  logic                reset,        // Clock
    input  logic                clk,          // Async reset, active high

    // Control port
    input  ps_reg_addr_e        i_ctrl_addr,
    input  logic                i_ctrl_wreq,
    input  logic [PS_WIDTH-1:0] i_ctrl_wdat,
    output logic [PS_WIDTH-1:0] o_ctrl_rdat,

    // Generated stream
    ps_stream_if.src            o_stream
);

    // ------------------------------
    // Internal state

    logic [PS_WIDTH-1:0] data_reg;    // Next word to send
    logic [PS_WIDTH-1:0] incr_reg;    // Step between words
    logic [PS_WIDTH-1:0] len_reg;     // Programmed packet length
    logic [PS_WIDTH-1:0] len_cnt;     // Words left in packet minus one
    logic [PS_WIDTH-1:0] amount_cnt;  // Words left in the run
    logic                val_reg;
    logic                eop_reg;

    logic wr_data;
    logic wr_incr;
    logic wr_len;
    logic wr_amount;
    logic xfer;                       // Word leaves on this edge

    // Write decode
    assign wr_data   = i_ctrl_wreq & (i_ctrl_addr == PS_REG_DATA);
    assign wr_incr   = i_ctrl_wreq & (i_ctrl_addr == PS_REG_INCR);
    assign wr_len    = i_ctrl_wreq & (i_ctrl_addr == PS_REG_LENGTH);
    assign wr_amount = i_ctrl_wreq & (i_ctrl_addr == PS_REG_AMOUNT);

    assign xfer = val_reg & o_stream.rdy;

    // ------------------------------
    // Programmable registers

    // Data word, written or stepped by the increment
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            data_reg <= '0;
        end else if (wr_data) begin
            data_reg <= i_ctrl_wdat;
        end else if (xfer) begin
            data_reg <= data_reg + incr_reg;  // Wraps mod 2^PS_WIDTH
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            incr_reg <= '0;
        end else if (wr_incr) begin
            incr_reg <= i_ctrl_wdat;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            len_reg <= '0;
        end else if (wr_len) begin
            len_reg <= i_ctrl_wdat;
        end
    end

    // ------------------------------
    // Run counters

    // Position inside the packet, zero marks the last word
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            len_cnt <= '0;
        end else if (wr_amount) begin
            len_cnt <= len_reg - 1'b1;  // Fresh packet at run start
        end else if (xfer) begin
            if (len_cnt == '0) begin
                len_cnt <= len_reg - 1'b1;  // Packet closed, reload
            end else begin
                len_cnt <= len_cnt - 1'b1;
            end
        end
    end

    // Remaining words, never wraps below zero
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            amount_cnt <= '0;
        end else if (wr_amount) begin
            amount_cnt <= i_ctrl_wdat;
        end else if (xfer && (amount_cnt != '0)) begin
            amount_cnt <= amount_cnt - 1'b1;
        end
    end

    // ------------------------------
    // Stream control

    // Valid rises on a non-zero AMOUNT write, falls after the last word
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            val_reg <= 1'b0;
        end else if (wr_amount) begin
            val_reg <= (i_ctrl_wdat != '0);  // Zero aborts the run
        end else if (xfer && (amount_cnt == 'd1)) begin
            val_reg <= 1'b0;
        end
    end

    // End of packet, prepared one word ahead
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            eop_reg <= 1'b0;
        end else if (wr_amount) begin
            // First word closes a packet if run or packet is one word long
            eop_reg <= (i_ctrl_wdat == 'd1) | (len_reg == 'd1);
        end else if (xfer) begin
            eop_reg <= (amount_cnt == 'd2)  // Next word ends the run
                     | (len_cnt == 'd1)     // Next word ends the packet
                     | (len_reg == 'd1);    // Every word is a packet
        end
    end

    assign o_stream.dat = data_reg;
    assign o_stream.val = val_reg;
    assign o_stream.eop = eop_reg;

    // Readback, no read strobe needed
    always_comb begin
        case (i_ctrl_addr)
            PS_REG_INCR:   o_ctrl_rdat = incr_reg;
            PS_REG_LENGTH: o_ctrl_rdat = len_reg;
            PS_REG_AMOUNT: o_ctrl_rdat = amount_cnt;  // Remaining count
            default:       o_ctrl_rdat = data_reg;
        endcase
    end

endmodule : ps_traffic_generator

//--- source/ps_stream_if.sv
interface ps_stream_if import ps_pkg::*; ();

    logic [PS_WIDTH-1:0] dat;  // Payload word
    logic                val;  // Word valid
    logic                eop;  // Last word of packet
    logic                rdy;  // Sink can take a word

    // Source side of a PacketStream link
    modport src (
        output dat,
        output val,
        output eop,
        input  rdy
    );

    // Sink side, mirror of src
    modport snk (
        input  dat,
        input  val,
        input  eop,
        output rdy
    );

endinterface : ps_stream_if

//--- source/ps_pkg.sv
package ps_pkg;

    // ------------------------------
    // Widths

    localparam int unsigned PS_WIDTH     = 8;   // Data word and control data
    localparam int unsigned PS_CNT_WIDTH = 16;  // Monitor statistics counters

    // ------------------------------
    // Control register map

    typedef enum logic [1:0] {
        PS_REG_DATA   = 2'd0,  // Current data word
        PS_REG_INCR   = 2'd1,  // Increment per transferred word
        PS_REG_LENGTH = 2'd2,  // Words per packet
        PS_REG_AMOUNT = 2'd3   // Remaining words, write starts a run
    } ps_reg_addr_e;

endpackage : ps_pkg
